// ==== src/mem_perf_pkg.sv ====
// Memory performance monitor
// Shared widths, address map and probe types

package mem_perf_pkg;

    // Port count and widths
    localparam int dcache_lanes   = 4;
    localparam int lane_cnt_bits  = 3;
    localparam int perf_ctr_bits  = 32;
    localparam int pending_bits   = 16;
    localparam int perf_addr_bits = 3;

    // Counter read address map
    // Address 7 is unmapped and reads as zero
    localparam logic [perf_addr_bits-1:0] perf_addr_ifetches       = perf_addr_bits'(0);
    localparam logic [perf_addr_bits-1:0] perf_addr_loads          = perf_addr_bits'(1);
    localparam logic [perf_addr_bits-1:0] perf_addr_stores         = perf_addr_bits'(2);
    localparam logic [perf_addr_bits-1:0] perf_addr_ifetch_lat     = perf_addr_bits'(3);
    localparam logic [perf_addr_bits-1:0] perf_addr_load_lat       = perf_addr_bits'(4);
    localparam logic [perf_addr_bits-1:0] perf_addr_icache_pending = perf_addr_bits'(5);
    localparam logic [perf_addr_bits-1:0] perf_addr_dcache_pending = perf_addr_bits'(6);

    // Instruction cache handshake wires as seen by the monitor
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_probe_t;

    // One bit per data cache lane in each field
    typedef struct packed {
        logic [dcache_lanes-1:0] req_valid;
        logic [dcache_lanes-1:0] req_rw;
        logic [dcache_lanes-1:0] req_ready;
        logic [dcache_lanes-1:0] rsp_valid;
        logic [dcache_lanes-1:0] rsp_ready;
    } dcache_probe_t;

    typedef struct packed {
        logic                    fetch;
        logic [pending_bits-1:0] pending;
    } icache_activity_t;

    // Per-cycle fire counts plus outstanding loads
    typedef struct packed {
        logic [lane_cnt_bits-1:0] loads;
        logic [lane_cnt_bits-1:0] stores;
        logic [pending_bits-1:0]  pending;
    } dcache_activity_t;

endpackage

// ==== src/icache_perf_tracker.sv ====
// Instruction cache traffic tracker

`timescale 1ns/1ps

module icache_perf_tracker import mem_perf_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  icache_probe_t    probe,
    output icache_activity_t activity
);

    logic                           req_fire;
    logic                           rsp_fire;
    logic signed [pending_bits-1:0] pending_delta;
    logic signed [pending_bits-1:0] pending_reads;

    assign req_fire = probe.req_valid & probe.req_ready;
    assign rsp_fire = probe.rsp_valid & probe.rsp_ready;

    // Net change in outstanding fetches this cycle
    always_comb begin
        case ({req_fire, rsp_fire})
            2'b10: begin
                pending_delta = pending_bits'(1);
            end
            2'b01: begin
                pending_delta = '1;
            end
            default: begin
                pending_delta = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else begin
            pending_reads <= pending_reads + pending_delta;
        end
    end

    // Fetch is reported in the cycle it fires
    assign activity.fetch   = req_fire;
    assign activity.pending = pending_reads;

endmodule

// ==== src/dcache_perf_tracker.sv ====
// Data cache traffic tracker
// Counts loads, stores and outstanding loads across all lanes

`timescale 1ns/1ps

module dcache_perf_tracker import mem_perf_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  dcache_probe_t    probe,
    output dcache_activity_t activity
);

    logic [dcache_lanes-1:0]        rd_req_fire;
    logic [dcache_lanes-1:0]        wr_req_fire;
    logic [dcache_lanes-1:0]        rsp_fire;
    logic [lane_cnt_bits-1:0]       load_count;
    logic [lane_cnt_bits-1:0]       store_count;
    logic [lane_cnt_bits-1:0]       rsp_count;
    logic signed [pending_bits-1:0] pending_delta;
    logic signed [pending_bits-1:0] pending_reads;

    // Number of set bits in a lane vector
    function automatic logic [lane_cnt_bits-1:0] pop_count(
        input logic [dcache_lanes-1:0] lanes
    );
        logic [lane_cnt_bits-1:0] count;
        count = '0;
        for (int i = 0; i < dcache_lanes; i++) begin
            count = count + lane_cnt_bits'(lanes[i]);
        end
        return count;
    endfunction

    for (genvar i = 0; i < dcache_lanes; i++) begin : g_lane
        logic req_fire;

        assign req_fire       = probe.req_valid[i] & probe.req_ready[i];
        // rw low is a read
        assign rd_req_fire[i] = req_fire & ~probe.req_rw[i];
        assign wr_req_fire[i] = req_fire & probe.req_rw[i];
        assign rsp_fire[i]    = probe.rsp_valid[i] & probe.rsp_ready[i];
    end

    assign load_count  = pop_count(rd_req_fire);
    assign store_count = pop_count(wr_req_fire);
    assign rsp_count   = pop_count(rsp_fire);

    // Loads open an outstanding read and responses close it
    assign pending_delta = $signed(pending_bits'(load_count))
                         - $signed(pending_bits'(rsp_count));

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else begin
            pending_reads <= pending_reads + pending_delta;
        end
    end

    assign activity.loads   = load_count;
    assign activity.stores  = store_count;
    assign activity.pending = pending_reads;

endmodule

// ==== src/perf_counter_bank.sv ====
// Memory performance counter bank
// Running counters with a registered read port

`timescale 1ns/1ps

module perf_counter_bank import mem_perf_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  icache_activity_t          icache_activity,
    input  dcache_activity_t          dcache_activity,
    input  logic                      read_valid,
    input  logic [perf_addr_bits-1:0] read_addr,
    output logic                      read_data_valid,
    output logic [perf_ctr_bits-1:0]  read_data
);

    // Per-cycle values widened to counter width
    logic [perf_ctr_bits-1:0] fetch_ext;
    logic [perf_ctr_bits-1:0] loads_ext;
    logic [perf_ctr_bits-1:0] stores_ext;
    logic [perf_ctr_bits-1:0] icache_pending_ext;
    logic [perf_ctr_bits-1:0] dcache_pending_ext;

    logic [perf_ctr_bits-1:0] ifetches;
    logic [perf_ctr_bits-1:0] loads;
    logic [perf_ctr_bits-1:0] stores;
    logic [perf_ctr_bits-1:0] ifetch_lat;
    logic [perf_ctr_bits-1:0] load_lat;

    logic [perf_ctr_bits-1:0] read_sel;

    assign fetch_ext  = perf_ctr_bits'(icache_activity.fetch);
    assign loads_ext  = perf_ctr_bits'(dcache_activity.loads);
    assign stores_ext = perf_ctr_bits'(dcache_activity.stores);

    // Pending counts never go below zero in normal traffic
    assign icache_pending_ext = perf_ctr_bits'(icache_activity.pending);
    assign dcache_pending_ext = perf_ctr_bits'(dcache_activity.pending);

    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else begin
            ifetches <= ifetches + fetch_ext;
            loads    <= loads + loads_ext;
            stores   <= stores + stores_ext;
        end
    end

    // Latency is the sum of outstanding reads over all cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_lat <= '0;
            load_lat   <= '0;
        end else begin
            ifetch_lat <= ifetch_lat + icache_pending_ext;
            load_lat   <= load_lat + dcache_pending_ext;
        end
    end

    always_comb begin
        case (read_addr)
            perf_addr_ifetches: begin
                read_sel = ifetches;
            end
            perf_addr_loads: begin
                read_sel = loads;
            end
            perf_addr_stores: begin
                read_sel = stores;
            end
            perf_addr_ifetch_lat: begin
                read_sel = ifetch_lat;
            end
            perf_addr_load_lat: begin
                read_sel = load_lat;
            end
            perf_addr_icache_pending: begin
                read_sel = icache_pending_ext;
            end
            perf_addr_dcache_pending: begin
                read_sel = dcache_pending_ext;
            end
            default: begin
                read_sel = '0;
            end
        endcase
    end

    // One response pulse per strobe after one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            read_data_valid <= 1'b0;
            read_data       <= '0;
        end else begin
            read_data_valid <= read_valid;
            if (read_valid) begin
                read_data <= read_sel;
            end
        end
    end

endmodule

// ==== src/mem_perf_monitor.sv ====
// Memory performance monitor top
// Cache trackers feeding the counter bank

`timescale 1ns/1ps

module mem_perf_monitor import mem_perf_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,

    // Observed cache handshakes
    input  icache_probe_t             icache_probe,
    input  dcache_probe_t             dcache_probe,

    // Counter read port
    input  logic                      read_valid,
    input  logic [perf_addr_bits-1:0] read_addr,
    output logic                      read_data_valid,
    output logic [perf_ctr_bits-1:0]  read_data
);

    icache_activity_t icache_activity;
    dcache_activity_t dcache_activity;

    icache_perf_tracker u_icache_tracker (
        .clk      (clk),
        .reset    (reset),
        .probe    (icache_probe),
        .activity (icache_activity)
    );

    dcache_perf_tracker u_dcache_tracker (
        .clk      (clk),
        .reset    (reset),
        .probe    (dcache_probe),
        .activity (dcache_activity)
    );

    perf_counter_bank u_counter_bank (
        .clk             (clk),
        .reset           (reset),
        .icache_activity (icache_activity),
        .dcache_activity (dcache_activity),
        .read_valid      (read_valid),
        .read_addr       (read_addr),
        .read_data_valid (read_data_valid),
        .read_data       (read_data)
    );

endmodule

// ==== tests/tb_mem_perf_monitor.sv ====
// Memory performance monitor testbench
// Replays recorded cache traffic and checks counter reads

`timescale 1ns/1ps

module tb_mem_perf_monitor import mem_perf_pkg::*; ();

    localparam int clk_period    = 100;
    localparam int drive_delay   = 5;
    localparam int reset_cycles  = 3;
    localparam int margin_cycles = 20;
    localparam int max_lines     = 256;

    // One line per cycle
    // Bits 63:60 icache probe, 59:40 dcache probe, 36 read_valid,
    // 34:32 read_addr, 31:0 expected read value
    logic [63:0] stim [max_lines];

    logic                      clk;
    logic                      reset;
    icache_probe_t             icache_probe;
    dcache_probe_t             dcache_probe;
    logic                      read_valid;
    logic [perf_addr_bits-1:0] read_addr;
    logic                      read_data_valid;
    logic [perf_ctr_bits-1:0]  read_data;

    int                        num_lines;
    logic                      lines_loaded;
    int                        value_errors;
    int                        pulse_errors;
    logic                      expect_valid;
    logic [perf_ctr_bits-1:0]  expect_data;
    logic [perf_addr_bits-1:0] expect_addr;

    mem_perf_monitor u_mem_perf_monitor (
        .clk             (clk),
        .reset           (reset),
        .icache_probe    (icache_probe),
        .dcache_probe    (dcache_probe),
        .read_valid      (read_valid),
        .read_addr       (read_addr),
        .read_data_valid (read_data_valid),
        .read_data       (read_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #(clk_period / 2) clk = ~clk;

    task automatic idle_inputs();
        icache_probe = '0;
        dcache_probe = '0;
        read_valid   = 1'b0;
        read_addr    = '0;
    endtask

    task automatic load_stimulus();
        $readmemh("tests/perf_input.dat", stim);
        num_lines = 0;
        while (num_lines < max_lines && !$isunknown(stim[num_lines])) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("No stimulus lines could be read from tests/perf_input.dat");
            pulse_errors++;
        end
        lines_loaded = 1'b1;
    endtask

    // Drive one cycle and note what the next read response must be
    task automatic apply_line(input int idx);
        logic [63:0] line;
        line         = stim[idx];
        icache_probe = line[63:60];
        dcache_probe = line[59:40];
        read_valid   = line[36];
        read_addr    = line[34:32];
        expect_valid = line[36];
        expect_addr  = line[34:32];
        expect_data  = line[31:0];
    endtask

    task automatic check_response();
        assert (read_data_valid == expect_valid) else begin
            if (expect_valid) begin
                $display("Read response for address %0d is missing at %0t",
                         expect_addr, $time);
            end else begin
                $display("Unexpected read_data_valid pulse at %0t", $time);
            end
            pulse_errors++;
        end
        if (expect_valid && read_data_valid) begin
            assert (read_data == expect_data) else begin
                $display("error: time %0t read_data (address %0d) expected %h actual %h",
                         $time, expect_addr, expect_data, read_data);
                value_errors++;
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        lines_loaded = 1'b0;
        value_errors = 0;
        pulse_errors = 0;
        expect_valid = 1'b0;
        expect_data  = '0;
        expect_addr  = '0;
        idle_inputs();
        load_stimulus();

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
        assert (read_data == '0) else begin
            $display("error: time %0t read_data expected %h actual %h",
                     $time, {perf_ctr_bits{1'b0}}, read_data);
            value_errors++;
        end

        for (int i = 0; i < num_lines; i++) begin
            @(posedge clk);
            #(drive_delay);
            check_response();
            apply_line(i);
        end
        @(posedge clk);
        #(drive_delay);
        check_response();
        idle_inputs();

        $display("%0d lines replayed, %0d value errors, %0d handshake errors",
                 num_lines, value_errors, pulse_errors);
        if (value_errors == 0 && pulse_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Run length follows the stimulus length
    initial begin
        wait (lines_loaded);
        #((num_lines + margin_cycles) * clk_period);
        $display("Watchdog timeout, the replay did not finish within %0d cycles",
                 num_lines + margin_cycles);
        $display("%0d lines replayed, %0d value errors, %0d handshake errors",
                 num_lines, value_errors, pulse_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== tests/perf_input.dat ====
// Columns: icache probe, dcache req_valid, req_rw, req_ready, rsp_valid, rsp_ready,
// read_valid, read_addr, expected read value (hex fields split by underscores)
// Reads of every address after reset
0_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_1_0_00000000
0_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_1_1_00000000
0_0_0_0_0_0_1_2_00000000
0_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_1_3_00000000
0_0_0_0_0_0_1_4_00000000
0_0_0_0_0_0_1_5_00000000
0_0_0_0_0_0_1_6_00000000
0_0_0_0_0_0_1_7_00000000
0_0_0_0_0_0_0_0_00000000
// Instruction fetches with delayed responses
c_0_0_0_0_0_0_0_00000000
c_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_0_0_00000000
3_0_0_0_0_0_0_0_00000000
f_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_1_0_00000003
0_0_0_0_0_0_1_3_00000007
3_0_0_0_0_0_1_5_00000001
0_0_0_0_0_0_1_5_00000000
0_0_0_0_0_0_1_3_00000009
// Data cache traffic on several lanes
0_f_5_f_0_0_0_0_00000000
0_7_4_3_1_1_0_0_00000000
0_8_8_8_6_6_1_1_00000004
0_0_0_0_0_0_1_2_00000003
0_0_0_0_0_0_1_4_00000006
0_0_0_0_8_8_1_6_00000001
0_0_0_0_0_0_1_6_00000000
0_0_0_0_0_0_1_4_00000008
// Valid without ready on both caches
a_f_3_0_f_0_0_0_00000000
5_0_0_f_0_f_0_0_00000000
a_f_3_0_f_0_1_0_00000003
8_f_0_0_0_0_1_1_00000004
0_0_0_0_0_0_1_2_00000003
// Open one fetch and two loads, then read all addresses back to back
c_3_0_3_0_0_0_0_00000000
0_0_0_0_0_0_0_0_00000000
0_0_0_0_0_0_1_0_00000004
0_0_0_0_0_0_1_1_00000006
0_0_0_0_0_0_1_2_00000003
0_0_0_0_0_0_1_3_0000000d
0_0_0_0_0_0_1_4_00000012
0_0_0_0_0_0_1_5_00000001
0_0_0_0_0_0_1_6_00000002
0_0_0_0_0_0_1_7_00000000
3_0_0_0_3_3_1_3_00000012
0_0_0_0_0_0_1_4_0000001c
0_0_0_0_0_0_1_5_00000000
0_0_0_0_0_0_1_6_00000000
0_0_0_0_0_0_0_0_00000000

// ==== mem_perf_monitor.f ====
src/mem_perf_pkg.sv
src/icache_perf_tracker.sv
src/dcache_perf_tracker.sv
src/perf_counter_bank.sv
src/mem_perf_monitor.sv
tests/tb_mem_perf_monitor.sv
